// ==== rtl/soc_bus_pkg.sv ====
package soc_bus_pkg;

    //////////////////////////////
    // data and address
    //////////////////////////////

    typedef logic [31:0] data_t;    // one bus word

    // bus view of an address
    typedef struct packed {
        logic [3:0]  region;        // decoded by main_bus only
        logic [27:0] offset;        // byte offset inside the region
    } addr_fields_t;

    // raw word for masters, split fields for bus and slaves
    typedef union packed {
        logic [31:0]  word;
        addr_fields_t f;
    } bus_addr_u;

    //////////////////////////////
    // transfer types
    //////////////////////////////

    // master port: valid is a level held until gnt
    // slave port: valid is a one-cycle select strobe
    typedef struct packed {
        logic      valid;
        logic      we;          // 1 write, 0 read
        bus_addr_u addr;
        data_t     wdata;
    } bus_req_t;

    // one-cycle pulse back to the granted master
    typedef struct packed {
        logic  valid;
        logic  err;             // unmapped region
        data_t rdata;           // undefined on writes
    } bus_rsp_t;

endpackage

// ==== rtl/soc_map_pkg.sv ====
package soc_map_pkg;

    //////////////////////////////
    // address map regions
    //////////////////////////////

    localparam logic [3:0] REGION_MEM    = 4'd0;
    localparam logic [3:0] REGION_PLIC   = 4'd1;
    localparam logic [3:0] REGION_TIMER0 = 4'd2;
    localparam logic [3:0] REGION_TIMER1 = 4'd3;
    // codes 4..15 unmapped, answered with err

    //////////////////////////////
    // register offsets
    //////////////////////////////

    // timer
    localparam logic [27:0] TMR_CTRL   = 28'h0;    // bit 0 enable
    localparam logic [27:0] TMR_CMP    = 28'h4;
    localparam logic [27:0] TMR_COUNT  = 28'h8;
    localparam logic [27:0] TMR_STATUS = 28'hC;    // bit 0 pending, w1c

    // plic
    localparam logic [27:0] PLIC_PENDING = 28'h0;  // read only
    localparam logic [27:0] PLIC_ENABLE  = 28'h4;
    localparam logic [27:0] PLIC_CLAIM   = 28'h8;  // read claims lowest id

    //////////////////////////////
    // interrupt sources
    //////////////////////////////

    // source 0 reserved, 1 and 4 not present here
    localparam int IRQ_TIMER0 = 2;
    localparam int IRQ_TIMER1 = 3;

    // configuration defaults
    localparam int NUM_IRQ_SRC       = 4;
    localparam int DEFAULT_MEM_WORDS = 256;

endpackage

// ==== rtl/main_bus.sv ====
`timescale 1ns/1ps

module main_bus (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // masters
    input  soc_bus_pkg::bus_req_t  sys_req_i,
    input  soc_bus_pkg::bus_req_t  dbg_req_i,
    output logic                   sys_gnt_o,
    output logic                   dbg_gnt_o,
    output soc_bus_pkg::bus_rsp_t  sys_rsp_o,
    output soc_bus_pkg::bus_rsp_t  dbg_rsp_o,
    // slaves
    output soc_bus_pkg::bus_req_t  mem_req_o,
    output soc_bus_pkg::bus_req_t  plic_req_o,
    output soc_bus_pkg::bus_req_t  tmr0_req_o,
    output soc_bus_pkg::bus_req_t  tmr1_req_o,
    input  soc_bus_pkg::data_t     mem_rdata_i,
    input  soc_bus_pkg::data_t     plic_rdata_i,
    input  soc_bus_pkg::data_t     tmr0_rdata_i,
    input  soc_bus_pkg::data_t     tmr1_rdata_i
);

    logic                  last_dbg_q;  // dbg got the previous grant
    logic                  sys_win;
    logic                  dbg_win;
    logic                  any_win;
    soc_bus_pkg::bus_req_t sel_req;     // request of the granted master
    logic [3:0]            sel_region;
    logic                  sys_rsp_q;
    logic                  dbg_rsp_q;
    logic [3:0]            region_q;    // region hit by the previous grant
    soc_bus_pkg::data_t    rsp_rdata;
    logic                  rsp_err;

    // copy of the request with valid turned into the slave strobe
    function automatic soc_bus_pkg::bus_req_t strobe(
        input soc_bus_pkg::bus_req_t req,
        input logic                  hit
    );
        soc_bus_pkg::bus_req_t r;
        r       = req;
        r.valid = hit;
        return r;
    endfunction

    //////////////////////////////
    // round-robin arbiter
    //////////////////////////////

    // a lone requester always wins, on a tie the one not served last
    assign sys_win = sys_req_i.valid & (~dbg_req_i.valid | last_dbg_q);
    assign dbg_win = dbg_req_i.valid & ~sys_win;
    assign any_win = sys_win | dbg_win;

    assign sys_gnt_o = sys_win;
    assign dbg_gnt_o = dbg_win;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_dbg_q <= 1'b1;             // sys takes the first tie
        end else if (any_win) begin
            last_dbg_q <= dbg_win;
        end
    end

    //////////////////////////////
    // region decoder
    //////////////////////////////

    assign sel_req    = dbg_win ? dbg_req_i : sys_req_i;
    assign sel_region = sel_req.addr.f.region;

    // strobe only in the grant cycle, unmapped codes hit nothing
    assign mem_req_o  = strobe(sel_req, any_win && sel_region == soc_map_pkg::REGION_MEM);
    assign plic_req_o = strobe(sel_req, any_win && sel_region == soc_map_pkg::REGION_PLIC);
    assign tmr0_req_o = strobe(sel_req, any_win && sel_region == soc_map_pkg::REGION_TIMER0);
    assign tmr1_req_o = strobe(sel_req, any_win && sel_region == soc_map_pkg::REGION_TIMER1);

    //////////////////////////////
    // response return
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sys_rsp_q <= 1'b0;
            dbg_rsp_q <= 1'b0;
            region_q  <= soc_map_pkg::REGION_MEM;
        end else begin
            sys_rsp_q <= sys_win;           // respond one cycle after gnt
            dbg_rsp_q <= dbg_win;
            if (any_win) region_q <= sel_region;
        end
    end

    // slaves present their registered data this cycle
    always_comb begin
        rsp_rdata = '0;
        rsp_err   = 1'b0;
        case (region_q)
            soc_map_pkg::REGION_MEM:    rsp_rdata = mem_rdata_i;
            soc_map_pkg::REGION_PLIC:   rsp_rdata = plic_rdata_i;
            soc_map_pkg::REGION_TIMER0: rsp_rdata = tmr0_rdata_i;
            soc_map_pkg::REGION_TIMER1: rsp_rdata = tmr1_rdata_i;
            default:                    rsp_err   = 1'b1;  // rdata stays zero
        endcase
    end

    assign sys_rsp_o = '{valid: sys_rsp_q, err: rsp_err, rdata: rsp_rdata};
    assign dbg_rsp_o = '{valid: dbg_rsp_q, err: rsp_err, rdata: rsp_rdata};

endmodule

// ==== rtl/main_memory.sv ====
`timescale 1ns/1ps

module main_memory #(
    parameter int MEM_WORDS = 256       // power of two
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  soc_bus_pkg::bus_req_t req_i,
    output soc_bus_pkg::data_t    rdata_o
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    soc_bus_pkg::data_t mem [MEM_WORDS];
    logic [25:0]        word_addr;      // offset in words
    logic [IDX_W-1:0]   idx;
    soc_bus_pkg::data_t rdata_q;

    // word index wraps modulo the array size
    assign word_addr = req_i.addr.f.offset[27:2];
    assign idx       = IDX_W'(word_addr % 26'(MEM_WORDS));

    //////////////////////////////
    // storage
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (req_i.valid && req_i.we) begin
            mem[idx] <= req_i.wdata;
        end
    end

    // read data one cycle after the strobe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else if (req_i.valid && !req_i.we) begin
            rdata_q <= mem[idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== rtl/soc_timer.sv ====
`timescale 1ns/1ps

module soc_timer (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  soc_bus_pkg::bus_req_t req_i,
    output soc_bus_pkg::data_t    rdata_o,
    output logic                  irq_o        // pending level to the plic
);

    logic               en_q;
    soc_bus_pkg::data_t cmp_q;
    soc_bus_pkg::data_t cnt_q;
    logic               pend_q;
    soc_bus_pkg::data_t rdata_q;
    logic               match;
    logic               wr;
    logic               rd;
    logic [27:0]        offset;

    assign offset = req_i.addr.f.offset;
    assign wr     = req_i.valid & req_i.we;
    assign rd     = req_i.valid & ~req_i.we;
    assign match  = en_q && (cnt_q == cmp_q);

    //////////////////////////////
    // counter and registers
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q   <= 1'b0;
            cmp_q  <= '0;
            cnt_q  <= '0;
            pend_q <= 1'b0;
        end else begin
            // free running, wraps to zero on compare
            if (en_q) cnt_q <= match ? '0 : cnt_q + 32'd1;
            if (match) pend_q <= 1'b1;
            // bus writes come last and take priority
            if (wr) begin
                case (offset)
                    soc_map_pkg::TMR_CTRL:   en_q  <= req_i.wdata[0];
                    soc_map_pkg::TMR_CMP:    cmp_q <= req_i.wdata;
                    soc_map_pkg::TMR_COUNT:  cnt_q <= req_i.wdata;
                    soc_map_pkg::TMR_STATUS: begin
                        if (req_i.wdata[0]) pend_q <= 1'b0;   // write 1 to clear
                    end
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////
    // read back
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else if (rd) begin
            case (offset)
                soc_map_pkg::TMR_CTRL:   rdata_q <= {31'd0, en_q};
                soc_map_pkg::TMR_CMP:    rdata_q <= cmp_q;
                soc_map_pkg::TMR_COUNT:  rdata_q <= cnt_q;
                soc_map_pkg::TMR_STATUS: rdata_q <= {31'd0, pend_q};
                default:                 rdata_q <= '0;   // hole in the map
            endcase
        end
    end

    assign rdata_o = rdata_q;
    assign irq_o   = pend_q;

endmodule

// ==== rtl/soc_plic.sv ====
`timescale 1ns/1ps

module soc_plic #(
    parameter int NUM_SRC = 4           // up to 32, source 0 reserved
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  soc_bus_pkg::bus_req_t req_i,
    input  logic [NUM_SRC-1:0]    src_i,
    output soc_bus_pkg::data_t    rdata_o,
    output logic                  irq_o       // platform interrupt
);

    // clears bit 0 wherever a source vector is formed
    localparam logic [NUM_SRC-1:0] SRC_MASK = {{(NUM_SRC-1){1'b1}}, 1'b0};

    logic [NUM_SRC-1:0] src_q;          // previous source levels
    logic [NUM_SRC-1:0] rise;
    logic [NUM_SRC-1:0] pend_q;
    logic [NUM_SRC-1:0] en_q;
    logic [NUM_SRC-1:0] active;
    logic [NUM_SRC-1:0] clr;
    logic               irq_q;
    soc_bus_pkg::data_t claim_id;
    soc_bus_pkg::data_t rdata_q;
    logic               claim_rd;
    logic [27:0]        offset;

    assign offset   = req_i.addr.f.offset;
    assign claim_rd = req_i.valid && !req_i.we && offset == soc_map_pkg::PLIC_CLAIM;

    //////////////////////////////
    // gateway and claim
    //////////////////////////////

    assign rise   = src_i & ~src_q & SRC_MASK;  // edge triggered
    assign active = pend_q & en_q & SRC_MASK;

    // lowest numbered active source wins, 0 when idle
    always_comb begin
        claim_id = '0;
        for (int i = NUM_SRC - 1; i >= 1; i--) begin
            if (active[i]) claim_id = soc_bus_pkg::data_t'(i);
        end
    end

    assign clr = claim_rd ? (NUM_SRC'(1) << claim_id) : '0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            src_q  <= '0;
            pend_q <= '0;
            en_q   <= '0;
            irq_q  <= 1'b0;
        end else begin
            src_q  <= src_i;
            pend_q <= (pend_q & ~clr) | rise;   // a new edge beats the claim
            irq_q  <= |active;                  // follows register update
            if (req_i.valid && req_i.we && offset == soc_map_pkg::PLIC_ENABLE) begin
                en_q <= req_i.wdata[NUM_SRC-1:0] & SRC_MASK;
            end
        end
    end

    //////////////////////////////
    // read back
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else if (req_i.valid && !req_i.we) begin
            case (offset)
                soc_map_pkg::PLIC_PENDING: rdata_q <= soc_bus_pkg::data_t'(pend_q);
                soc_map_pkg::PLIC_ENABLE:  rdata_q <= soc_bus_pkg::data_t'(en_q);
                soc_map_pkg::PLIC_CLAIM:   rdata_q <= claim_id;
                default:                   rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_q;
    assign irq_o   = irq_q;

endmodule

// ==== rtl/soc_top.sv ====
`timescale 1ns/1ps

module soc_top #(
    parameter int MEM_WORDS = soc_map_pkg::DEFAULT_MEM_WORDS,
    parameter int NUM_SRC   = soc_map_pkg::NUM_IRQ_SRC
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // system host port
    input  soc_bus_pkg::bus_req_t sys_req_i,
    output logic                  sys_gnt_o,
    output soc_bus_pkg::bus_rsp_t sys_rsp_o,
    // debug host port
    input  soc_bus_pkg::bus_req_t dbg_req_i,
    output logic                  dbg_gnt_o,
    output soc_bus_pkg::bus_rsp_t dbg_rsp_o,
    output logic                  irq_o         // platform interrupt
);

    soc_bus_pkg::bus_req_t mem_req, plic_req, tmr0_req, tmr1_req;
    soc_bus_pkg::data_t    mem_rdata, plic_rdata, tmr0_rdata, tmr1_rdata;
    logic                  tmr0_irq, tmr1_irq;
    logic [NUM_SRC-1:0]    plic_src;

    // timers on their fixed lines, others tied off
    always_comb begin
        plic_src = '0;
        plic_src[soc_map_pkg::IRQ_TIMER0] = tmr0_irq;
        plic_src[soc_map_pkg::IRQ_TIMER1] = tmr1_irq;
    end

    //////////////////////////////
    // shared bus
    //////////////////////////////

    main_bus main_bus_u (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .sys_req_i    ( sys_req_i  ),
        .dbg_req_i    ( dbg_req_i  ),
        .sys_gnt_o    ( sys_gnt_o  ),
        .dbg_gnt_o    ( dbg_gnt_o  ),
        .sys_rsp_o    ( sys_rsp_o  ),
        .dbg_rsp_o    ( dbg_rsp_o  ),
        .mem_req_o    ( mem_req    ),
        .plic_req_o   ( plic_req   ),
        .tmr0_req_o   ( tmr0_req   ),
        .tmr1_req_o   ( tmr1_req   ),
        .mem_rdata_i  ( mem_rdata  ),
        .plic_rdata_i ( plic_rdata ),
        .tmr0_rdata_i ( tmr0_rdata ),
        .tmr1_rdata_i ( tmr1_rdata )
    );

    //////////////////////////////
    // slaves
    //////////////////////////////

    main_memory #(.MEM_WORDS(MEM_WORDS)) main_memory_u (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .req_i   ( mem_req   ),
        .rdata_o ( mem_rdata )
    );

    soc_timer timer0_u (
        .clk_i   ( clk_i      ),
        .rst_n_i ( rst_n_i    ),
        .req_i   ( tmr0_req   ),
        .rdata_o ( tmr0_rdata ),
        .irq_o   ( tmr0_irq   )
    );

    soc_timer timer1_u (
        .clk_i   ( clk_i      ),
        .rst_n_i ( rst_n_i    ),
        .req_i   ( tmr1_req   ),
        .rdata_o ( tmr1_rdata ),
        .irq_o   ( tmr1_irq   )
    );

    soc_plic #(.NUM_SRC(NUM_SRC)) soc_plic_u (
        .clk_i   ( clk_i      ),
        .rst_n_i ( rst_n_i    ),
        .req_i   ( plic_req   ),
        .src_i   ( plic_src   ),
        .rdata_o ( plic_rdata ),
        .irq_o   ( irq_o      )
    );

endmodule

// ==== dv/soc_checker.sv ====
`timescale 1ns/1ps

module soc_checker #(
    parameter int MEM_WORDS = 256,
    parameter int NUM_SRC   = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  soc_bus_pkg::bus_req_t sys_req_i,
    input  soc_bus_pkg::bus_req_t dbg_req_i,
    input  logic                  sys_gnt_i,
    input  logic                  dbg_gnt_i,
    input  soc_bus_pkg::bus_rsp_t sys_rsp_i,
    input  soc_bus_pkg::bus_rsp_t dbg_rsp_i,
    input  logic                  irq_i,
    input  logic                  chk_rd_i,     // scripted sys read with known data
    input  logic [31:0]           exp_rd_i,
    input  logic                  quiet_i,      // irq must stay low
    output int                    errors_o
);

    // response owed one cycle after a grant
    typedef struct packed {
        logic        valid;
        logic        to_dbg;
        logic        err;
        logic        chk;       // rdata known
        logic [31:0] data;
    } expect_t;

    logic [31:0]           mem_model [MEM_WORDS];
    logic                  known [MEM_WORDS];  // written since reset
    expect_t               pend;               // from the previous grant
    expect_t               nxt;
    logic                  last_dbg;           // grant history
    logic                  to_dbg;
    logic                  any_req;
    logic [NUM_SRC-1:0]    en_mirror;          // plic enable register
    int                    en_zero_cycles;
    int                    errors = 0;
    soc_bus_pkg::bus_req_t req;
    logic [3:0]            region;
    int                    idx;

    assign errors_o = errors;

    task flag_mismatch(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task check_response(input soc_bus_pkg::bus_rsp_t rsp, input logic due, input string name);
        if (rsp.valid !== due) begin
            flag_mismatch($sformatf("%s response valid %b, expected %b", name, rsp.valid, due));
        end else if (due) begin
            if (rsp.err !== pend.err) begin
                flag_mismatch($sformatf("%s response err %b, expected %b", name, rsp.err,
                                        pend.err));
            end else if (pend.err && rsp.rdata !== 32'd0) begin
                flag_mismatch($sformatf("%s error response rdata %h, expected 0", name,
                                        rsp.rdata));
            end else if (pend.chk && rsp.rdata !== pend.data) begin
                flag_mismatch($sformatf("%s response rdata %h, expected %h", name, rsp.rdata,
                                        pend.data));
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend           = '0;
            last_dbg       = 1'b1;      // sys takes the first contest
            en_mirror      = '0;
            en_zero_cycles = 0;
            for (int i = 0; i < MEM_WORDS; i++) known[i] = 1'b0;
        end else begin
            check_response(sys_rsp_i, pend.valid && !pend.to_dbg, "sys");
            check_response(dbg_rsp_i, pend.valid && pend.to_dbg, "dbg");

            if (quiet_i && irq_i !== 1'b0) begin
                flag_mismatch("irq_o high while no enabled source may be pending");
            end else if (en_zero_cycles >= 2 && irq_i !== 1'b0) begin
                flag_mismatch("irq_o high with every plic source disabled");
            end

            //////////////////////////////
            // arbitration
            //////////////////////////////
            any_req = sys_req_i.valid || dbg_req_i.valid;
            if (sys_req_i.valid && dbg_req_i.valid) to_dbg = !last_dbg;  // round robin
            else to_dbg = dbg_req_i.valid;                               // lone requester
            if (sys_gnt_i !== (any_req && !to_dbg) || dbg_gnt_i !== (any_req && to_dbg)) begin
                flag_mismatch($sformatf("gnt sys %b dbg %b for req sys %b dbg %b, last dbg %b",
                    sys_gnt_i, dbg_gnt_i, sys_req_i.valid, dbg_req_i.valid, last_dbg));
            end

            //////////////////////////////
            // expected response
            //////////////////////////////
            nxt = '0;
            if (any_req) begin
                req        = to_dbg ? dbg_req_i : sys_req_i;
                last_dbg   = to_dbg;
                nxt.valid  = 1'b1;
                nxt.to_dbg = to_dbg;
                region     = req.addr.word[31:28];
                idx        = int'(req.addr.word[27:2]) % MEM_WORDS;   // word index wraps
                if (region == soc_map_pkg::REGION_MEM) begin
                    if (req.we) begin
                        mem_model[idx] = req.wdata;
                        known[idx]     = 1'b1;
                    end else begin
                        nxt.chk  = known[idx];
                        nxt.data = mem_model[idx];
                    end
                end else if (region == soc_map_pkg::REGION_PLIC ||
                             region == soc_map_pkg::REGION_TIMER0 ||
                             region == soc_map_pkg::REGION_TIMER1) begin
                    if (region == soc_map_pkg::REGION_PLIC && req.we &&
                        req.addr.word[27:0] == soc_map_pkg::PLIC_ENABLE) begin
                        en_mirror = req.wdata[NUM_SRC-1:0] & ~NUM_SRC'(1);  // source 0 fixed
                    end
                    nxt.chk  = !req.we && !to_dbg && chk_rd_i;
                    nxt.data = exp_rd_i;
                end else begin
                    nxt.err = 1'b1;     // unmapped region
                end
            end
            pend = nxt;

            // irq_o trails the enable register by two cycles
            if (en_mirror != '0) en_zero_cycles = 0;
            else if (en_zero_cycles < 2) en_zero_cycles++;
        end
    end

endmodule

// ==== dv/tb_soc.sv ====
`timescale 1ns/1ps

module tb_soc;

    localparam int MEM_WORDS   = soc_map_pkg::DEFAULT_MEM_WORDS;
    localparam int NUM_SRC     = soc_map_pkg::NUM_IRQ_SRC;
    localparam int GNT_TIMEOUT = 20;
    localparam int IRQ_TIMEOUT = 200;

    // register addresses with the region on top of the offset
    localparam logic [31:0] PLIC_EN    = {soc_map_pkg::REGION_PLIC, soc_map_pkg::PLIC_ENABLE};
    localparam logic [31:0] PLIC_CLAIM = {soc_map_pkg::REGION_PLIC, soc_map_pkg::PLIC_CLAIM};
    localparam logic [31:0] T0_CTRL    = {soc_map_pkg::REGION_TIMER0, soc_map_pkg::TMR_CTRL};
    localparam logic [31:0] T0_CMP     = {soc_map_pkg::REGION_TIMER0, soc_map_pkg::TMR_CMP};
    localparam logic [31:0] T0_STATUS  = {soc_map_pkg::REGION_TIMER0, soc_map_pkg::TMR_STATUS};
    localparam logic [31:0] T1_CTRL    = {soc_map_pkg::REGION_TIMER1, soc_map_pkg::TMR_CTRL};
    localparam logic [31:0] T1_CMP     = {soc_map_pkg::REGION_TIMER1, soc_map_pkg::TMR_CMP};
    localparam logic [31:0] T1_STATUS  = {soc_map_pkg::REGION_TIMER1, soc_map_pkg::TMR_STATUS};

    logic                  clk;
    logic                  rst_n;
    soc_bus_pkg::bus_req_t sys_req;
    soc_bus_pkg::bus_req_t dbg_req;
    logic                  sys_gnt;
    logic                  dbg_gnt;
    soc_bus_pkg::bus_rsp_t sys_rsp;
    soc_bus_pkg::bus_rsp_t dbg_rsp;
    logic                  irq;
    logic                  chk_rd;      // checker compares the next sys read
    logic [31:0]           exp_rd;
    logic                  quiet;       // window where irq must stay low
    int                    errors;
    int                    timeouts;
    integer                seed;

    soc_top #(.MEM_WORDS(MEM_WORDS), .NUM_SRC(NUM_SRC)) DUT (
        .clk_i     ( clk     ),
        .rst_n_i   ( rst_n   ),
        .sys_req_i ( sys_req ),
        .sys_gnt_o ( sys_gnt ),
        .sys_rsp_o ( sys_rsp ),
        .dbg_req_i ( dbg_req ),
        .dbg_gnt_o ( dbg_gnt ),
        .dbg_rsp_o ( dbg_rsp ),
        .irq_o     ( irq     )
    );

    soc_checker #(.MEM_WORDS(MEM_WORDS), .NUM_SRC(NUM_SRC)) checker_u (
        .clk_i     ( clk     ),
        .rst_n_i   ( rst_n   ),
        .sys_req_i ( sys_req ),
        .dbg_req_i ( dbg_req ),
        .sys_gnt_i ( sys_gnt ),
        .dbg_gnt_i ( dbg_gnt ),
        .sys_rsp_i ( sys_rsp ),
        .dbg_rsp_i ( dbg_rsp ),
        .irq_i     ( irq     ),
        .chk_rd_i  ( chk_rd  ),
        .exp_rd_i  ( exp_rd  ),
        .quiet_i   ( quiet   ),
        .errors_o  ( errors  )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    //////////////////////////////
    // bus master tasks
    //////////////////////////////

    // called at a falling edge and returns at the falling edge of the response cycle
    task automatic bus_access(input logic to_dbg, input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic chk,
                              input logic [31:0] exp, output logic [31:0] rdata);
        soc_bus_pkg::bus_req_t req;
        int                    waited;
        logic                  granted;
        req.valid     = 1'b1;
        req.we        = we;
        req.addr.word = addr;
        req.wdata     = wdata;
        granted       = 1'b0;
        waited        = 0;
        if (to_dbg) dbg_req = req;
        else begin
            sys_req = req;
            chk_rd  = chk;
            exp_rd  = exp;
        end
        while (!granted && waited < GNT_TIMEOUT) begin
            @(posedge clk);
            granted = to_dbg ? dbg_gnt : sys_gnt;
            waited++;
        end
        @(negedge clk);
        if (!granted) begin
            timeouts++;
            $display("Timeout: %s master was not granted within %0d cycles",
                     to_dbg ? "dbg" : "sys", GNT_TIMEOUT);
        end
        rdata     = to_dbg ? dbg_rsp.rdata : sys_rsp.rdata;    // response cycle
        req.valid = 1'b0;
        if (to_dbg) dbg_req = req;
        else begin
            sys_req = req;
            chk_rd  = 1'b0;
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        bus_access(1'b0, 1'b1, addr, data, 1'b0, '0, rd);
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic chk, input logic [31:0] exp,
                            output logic [31:0] rdata);
        bus_access(1'b0, 1'b0, addr, '0, chk, exp, rdata);
    endtask

    task automatic wait_irq(input string what);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < IRQ_TIMEOUT) begin
            @(posedge clk);
            seen = (irq === 1'b1);
            waited++;
        end
        @(negedge clk);
        if (!seen) begin
            timeouts++;
            $display("Timeout: irq_o did not rise %s", what);
        end
    endtask

    task automatic watch_irq_low(input int cycles);
        quiet = 1'b1;
        repeat (cycles) @(negedge clk);
        quiet = 1'b0;
    endtask

    //////////////////////////////
    // stimulus phases
    //////////////////////////////

    // memory traffic and a few unmapped hits over 512 word indexes that alias the 256 words
    task automatic random_traffic(input logic to_dbg, input int count);
        logic [31:0] addr;
        logic [31:0] rd;
        int          kind;
        for (int n = 0; n < count; n++) begin
            kind = int'($unsigned($random(seed)) % 10);
            if (kind == 0) addr = {4'(4 + $unsigned($random(seed)) % 12), 28'($random(seed))};
            else addr = {4'h0, 28'(($unsigned($random(seed)) % 512) << 2)};
            bus_access(to_dbg, kind inside {[1:4]}, addr, $random(seed), 1'b0, '0, rd);
            repeat (int'($unsigned($random(seed)) % 3)) @(negedge clk);    // idle gap
        end
    endtask

    task automatic interrupt_phases();
        logic [31:0] rd;
        int          polls;
        // timer 0 on source 2
        write_reg(PLIC_EN, 32'h1 << soc_map_pkg::IRQ_TIMER0);
        write_reg(T0_CMP, 32'd5);
        write_reg(T0_CTRL, 32'd1);
        wait_irq("after timer 0 was started");
        read_reg(PLIC_CLAIM, 1'b1, 32'(soc_map_pkg::IRQ_TIMER0), rd);
        read_reg(PLIC_CLAIM, 1'b1, 32'd0, rd);      // nothing left
        write_reg(T0_CTRL, 32'd0);                  // stop first so no new compare arrives
        write_reg(T0_STATUS, 32'd1);
        read_reg(T0_STATUS, 1'b1, 32'd0, rd);       // pending flag gone
        watch_irq_low(20);

        // timer 1 pending while source 3 is masked
        write_reg(PLIC_EN, 32'd0);
        write_reg(T1_CMP, 32'd3);
        write_reg(T1_CTRL, 32'd1);
        polls = 0;
        rd    = '0;
        while (rd[0] !== 1'b1 && polls < IRQ_TIMEOUT) begin
            read_reg(T1_STATUS, 1'b0, '0, rd);
            polls++;
        end
        if (rd[0] !== 1'b1) begin
            timeouts++;
            $display("Timeout: timer 1 never reported a pending compare");
        end
        write_reg(T1_CTRL, 32'd0);                  // pending level stays
        watch_irq_low(20);
        write_reg(PLIC_EN, 32'h1 << soc_map_pkg::IRQ_TIMER1);
        wait_irq("after source 3 was enabled");
        read_reg(PLIC_CLAIM, 1'b1, 32'(soc_map_pkg::IRQ_TIMER1), rd);
        write_reg(T1_STATUS, 32'd1);
    endtask

    initial begin
        seed     = 32'h94eb;
        rst_n    = 1'b0;
        sys_req  = '0;
        dbg_req  = '0;
        chk_rd   = 1'b0;
        exp_rd   = '0;
        quiet    = 1'b0;
        timeouts = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // both ports start together so the first contest happens at once
        fork
            random_traffic(1'b0, 300);
            random_traffic(1'b1, 300);
        join
        interrupt_phases();
        repeat (4) @(negedge clk);      // last response reaches the checker

        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/soc_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/main_bus.sv
rtl/main_memory.sv
rtl/soc_timer.sv
rtl/soc_plic.sv
rtl/soc_top.sv
dv/soc_checker.sv
dv/tb_soc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= Simulation PASSED

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and look for the pass line"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
